// ==== src/core_pkg.sv ====
package core_pkg;

    // *************************************************************************
    // sizes
    // *************************************************************************
    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int imem_depth = 64;
    localparam int rx_depth   = 16;

    typedef logic [$clog2(reg_count)-1:0]  reg_idx_t;
    typedef logic [$clog2(imem_depth)-1:0] imem_addr_t;

    // jal link target
    localparam reg_idx_t link_reg = 5'd28;

    // *************************************************************************
    // opcodes and special funct codes
    // *************************************************************************
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b011000;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_slli    = 6'b111110;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_bl      = 6'b000001;
    localparam logic [5:0] op_bg      = 6'b000110;

    localparam logic [5:0] fn_add = 6'b100000;
    localparam logic [5:0] fn_sub = 6'b100010;
    localparam logic [5:0] fn_mov = 6'b001001;
    localparam logic [5:0] fn_jr  = 6'b001000;
    localparam logic [5:0] fn_ret = 6'b000000;
    localparam logic [5:0] fn_in  = 6'b101010;
    localparam logic [5:0] fn_out = 6'b010101;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            reg_idx_t   rs;
            reg_idx_t   rt;
            reg_idx_t   rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  op;
            reg_idx_t    rs;
            reg_idx_t    rt;
            logic [15:0] imm16;
        } i_fmt;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } j_fmt;
    } instr_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_t          instr;
        logic            pred_taken;
    } fd_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_t          instr;
        logic [xlen-1:0] opa;
        logic [xlen-1:0] opb;
        logic            pred_taken;
    } de_t;

    typedef struct packed {
        logic            we;
        reg_idx_t        rd;
        logic [xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    function automatic logic is_cond_branch(logic [5:0] op);
        return op == op_beq || op == op_bne || op == op_bl || op == op_bg;
    endfunction

    function automatic logic [xlen-1:0] simm(instr_t i);
        return {{(xlen-16){i.i_fmt.imm16[15]}}, i.i_fmt.imm16};
    endfunction

    // bit 5 set when the instruction writes a register
    function automatic logic [5:0] dest_of(instr_t i);
        logic [5:0] d;
        d = 6'b0;
        case (i.r_fmt.op)
            op_special: begin
                case (i.r_fmt.funct)
                    fn_add, fn_sub: d = {1'b1, i.r_fmt.rd};
                    fn_mov:         d = {1'b1, i.r_fmt.rt};
                    fn_in:          d = {1'b1, i.r_fmt.rs};
                    default:        d = 6'b0;
                endcase
            end
            op_addi, op_slli: d = {1'b1, i.i_fmt.rt};
            op_jal:           d = {1'b1, link_reg};
            default:          d = 6'b0;
        endcase
        return d;
    endfunction

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      prog_we,
    input  core_pkg::imem_addr_t      prog_addr,
    input  core_pkg::instr_t          prog_data,
    input  logic                      stall,
    input  core_pkg::redirect_t       redirect,
    input  logic                      halted,
    input  logic [core_pkg::xlen-1:0] jr_src,
    input  logic                      jr_busy,
    output core_pkg::reg_idx_t        jr_rs,
    output core_pkg::fd_t             fd
);
    import core_pkg::*;

    instr_t          imem [imem_depth];
    logic [xlen-1:0] pc;
    instr_t          inst;
    logic            stopped;
    logic            is_jr;
    logic            jr_wait;
    logic [5:0]      fd_dest;

    assign inst  = imem[pc[$bits(imem_addr_t)-1:0]];
    assign jr_rs = inst.r_fmt.rs;
    assign is_jr = inst.r_fmt.op == op_special && inst.r_fmt.funct == fn_jr;

    // a writer still in decode has not set its busy bit yet
    assign fd_dest = dest_of(fd.instr);
    assign jr_wait = jr_busy || (fd.valid && fd_dest[5] && fd_dest[4:0] == jr_rs);

    always_ff @(posedge clk) begin
        if (!rstn && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc       <= '0;
            stopped  <= 1'b0;
            fd.valid <= 1'b0;
        end else if (redirect.valid) begin
            pc       <= redirect.target;
            stopped  <= 1'b0;
            fd.valid <= 1'b0;
        end else if (halted || stopped) begin
            fd.valid <= 1'b0;
        end else if (!stall) begin
            fd.valid      <= !(is_jr && jr_wait);
            fd.pc         <= pc;
            fd.instr      <= inst;
            // every conditional branch is predicted taken
            fd.pred_taken <= is_cond_branch(inst.r_fmt.op);
            case (inst.r_fmt.op)
                op_j, op_jal: pc <= {{(xlen-26){1'b0}}, inst.j_fmt.target};
                op_beq, op_bne, op_bl, op_bg: pc <= pc + simm(inst);
                op_special: begin
                    if (is_jr) begin
                        if (!jr_wait) begin
                            pc <= jr_src;
                        end
                    end else if (inst.r_fmt.funct == fn_ret) begin
                        // nothing after ret is fetched
                        stopped <= 1'b1;
                    end else begin
                        pc <= pc + 1;
                    end
                end
                default: pc <= pc + 1;
            endcase
        end
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_pkg::reg_idx_t        ra_a,
    input  core_pkg::reg_idx_t        ra_b,
    input  core_pkg::reg_idx_t        ra_j,
    input  core_pkg::reg_idx_t        set_rd,
    input  logic                      set_en,
    input  core_pkg::wb_t             wb,
    input  logic                      flush_busy,
    output logic [core_pkg::xlen-1:0] rd_a,
    output logic [core_pkg::xlen-1:0] rd_b,
    output logic [core_pkg::xlen-1:0] rd_j,
    output logic                      busy_a,
    output logic                      busy_b,
    output logic                      busy_j
);
    import core_pkg::*;

    logic [xlen-1:0]      regs [reg_count];
    logic [reg_count-1:0] busy;

    assign rd_a   = regs[ra_a];
    assign rd_b   = regs[ra_b];
    assign rd_j   = regs[ra_j];
    assign busy_a = busy[ra_a];
    assign busy_b = busy[ra_b];
    assign busy_j = busy[ra_j];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // scoreboard, a new issue to the same register outranks the writeback
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= '0;
        end else if (flush_busy) begin
            busy <= '0;
        end else begin
            if (wb.we) begin
                busy[wb.rd] <= 1'b0;
            end
            if (set_en) begin
                busy[set_rd] <= 1'b1;
            end
        end
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_pkg::fd_t             fd,
    input  logic [core_pkg::xlen-1:0] rd_a,
    input  logic [core_pkg::xlen-1:0] rd_b,
    input  logic                      busy_a,
    input  logic                      busy_b,
    input  logic                      word_ok,
    input  logic [core_pkg::xlen-1:0] rx_word,
    input  logic                      tx_busy,
    input  core_pkg::redirect_t       redirect,
    input  logic                      ex_branch,
    input  logic                      ex_out,
    output core_pkg::reg_idx_t        ra_a,
    output core_pkg::reg_idx_t        ra_b,
    output core_pkg::reg_idx_t        set_rd,
    output logic                      set_en,
    output logic                      pop,
    output logic                      stall,
    output core_pkg::de_t             de
);
    import core_pkg::*;

    instr_t     ins;
    logic       use_a;
    logic       use_b;
    logic       use_imm;
    logic       is_in;
    logic       is_out;
    logic [5:0] dest;
    logic [5:0] ex_dest;
    logic       hazard;
    logic       issue;

    assign ins     = fd.instr;
    assign ra_a    = ins.r_fmt.rs;
    assign ra_b    = ins.r_fmt.rt;
    assign dest    = dest_of(ins);
    assign ex_dest = dest_of(de.instr);
    assign set_rd  = dest[4:0];

    always_comb begin
        use_a   = 1'b0;
        use_b   = 1'b0;
        use_imm = 1'b0;
        is_in   = 1'b0;
        is_out  = 1'b0;
        case (ins.r_fmt.op)
            op_special: begin
                case (ins.r_fmt.funct)
                    fn_add, fn_sub: begin
                        use_a = 1'b1;
                        use_b = 1'b1;
                    end
                    fn_mov: use_a = 1'b1;
                    fn_in:  is_in = 1'b1;
                    fn_out: begin
                        use_a  = 1'b1;
                        is_out = 1'b1;
                    end
                    default: ;
                endcase
            end
            op_addi, op_slli: begin
                use_a   = 1'b1;
                use_imm = 1'b1;
            end
            op_beq, op_bne, op_bl, op_bg: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            default: ;
        endcase
    end

    // same destination in execute would lose its busy bit at that writeback
    // in waits for a full word and for any branch to resolve
    assign hazard = (use_a && busy_a) || (use_b && busy_b)
                 || (dest[5] && de.valid && ex_dest[5] && ex_dest[4:0] == dest[4:0])
                 || (is_in && (!word_ok || ex_branch))
                 || (is_out && (tx_busy || ex_out));

    assign stall  = fd.valid && hazard;
    assign issue  = fd.valid && !hazard && !redirect.valid;
    assign set_en = issue && dest[5];
    assign pop    = issue && is_in;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            de.valid <= 1'b0;
        end else begin
            de.valid <= issue;
        end
        de.pc         <= fd.pc;
        de.instr      <= ins;
        de.opa        <= is_in ? rx_word : rd_a;
        de.opb        <= use_imm ? simm(ins) : rd_b;
        de.pred_taken <= fd.pred_taken;
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::de_t       de,
    output core_pkg::wb_t       wb,
    output core_pkg::redirect_t redirect,
    output logic                flush_busy,
    output logic                ex_branch,
    output logic                ex_out,
    output logic                tx_load,
    output logic [7:0]          tx_byte,
    output logic                halted
);
    import core_pkg::*;

    instr_t          ins;
    logic            v;
    logic            is_branch;
    logic            is_ret;
    logic            is_out;
    logic            taken;
    logic [5:0]      dest;
    logic [xlen-1:0] result;

    assign ins       = de.instr;
    assign v         = de.valid && !halted;
    assign is_branch = is_cond_branch(ins.r_fmt.op);
    assign is_ret    = ins.r_fmt.op == op_special && ins.r_fmt.funct == fn_ret;
    assign is_out    = ins.r_fmt.op == op_special && ins.r_fmt.funct == fn_out;
    assign dest      = dest_of(ins);

    // *************************************************************************
    // alu
    // *************************************************************************
    always_comb begin
        case (ins.r_fmt.op)
            op_special: begin
                case (ins.r_fmt.funct)
                    fn_add:  result = de.opa + de.opb;
                    fn_sub:  result = de.opa - de.opb;
                    // mov and in pass opa through
                    default: result = de.opa;
                endcase
            end
            op_addi: result = de.opa + de.opb;
            op_slli: result = de.opa << de.opb;
            // jal link
            default: result = de.pc + 1;
        endcase
    end

    // *************************************************************************
    // branch resolution with signed compares
    // *************************************************************************
    always_comb begin
        case (ins.r_fmt.op)
            op_beq:  taken = de.opa == de.opb;
            op_bne:  taken = de.opa != de.opb;
            op_bl:   taken = $signed(de.opa) < $signed(de.opb);
            op_bg:   taken = $signed(de.opa) > $signed(de.opb);
            default: taken = 1'b0;
        endcase
    end

    // only a branch that falls through can mispredict
    assign redirect.valid  = v && is_branch && taken != de.pred_taken;
    assign redirect.target = de.pc + 1;
    assign flush_busy      = redirect.valid;
    assign ex_branch       = v && is_branch;
    assign ex_out          = v && is_out;
    assign tx_load         = ex_out;
    assign tx_byte         = de.opa[7:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb.we  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb.we <= v && dest[5];
            if (v && is_ret) begin
                halted <= 1'b1;
            end
        end
        wb.rd   <= dest[4:0];
        wb.data <= result;
    end

endmodule

// ==== src/rx_buffer.sv ====
`timescale 1ns/1ps

module rx_buffer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      rx_req,
    input  logic [7:0]                rx_data,
    input  logic                      pop,
    output logic                      rx_ack,
    output logic                      word_ok,
    output logic [core_pkg::xlen-1:0] rx_word
);
    import core_pkg::*;

    logic [7:0]                  q [rx_depth];
    logic [$clog2(rx_depth)-1:0] wr_ptr;
    logic [$clog2(rx_depth)-1:0] rd_ptr;
    logic [$clog2(rx_depth):0]   count;
    logic                        push;

    // one byte per request, held off while the queue is full
    assign push    = rx_req && !rx_ack && count != rx_depth;
    assign word_ok = count >= 4;

    // little endian, oldest byte lowest
    assign rx_word = {q[rd_ptr + 2'd3], q[rd_ptr + 2'd2], q[rd_ptr + 2'd1], q[rd_ptr]};

    always_ff @(posedge clk) begin
        if (push) begin
            q[wr_ptr] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rx_ack <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                rx_ack <= 1'b1;
            end else if (!rx_req) begin
                rx_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 3'd4;
            end
            count <= count + push - {pop, 2'b00};
        end
    end

endmodule

// ==== src/tx_port.sv ====
`timescale 1ns/1ps

module tx_port (
    input  logic       clk,
    input  logic       rstn,
    input  logic       load,
    input  logic [7:0] byte_in,
    input  logic       tx_ack,
    output logic       tx_req,
    output logic [7:0] tx_data,
    output logic       busy
);
    // ack seen, waiting for it to drop
    logic rel;

    assign busy = tx_req || rel;

    always_ff @(posedge clk) begin
        if (load && !busy) begin
            tx_data <= byte_in;
        end
    end

    // idle -> request -> release -> idle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_req <= 1'b0;
            rel    <= 1'b0;
        end else if (!busy) begin
            tx_req <= load;
        end else if (tx_req && tx_ack) begin
            tx_req <= 1'b0;
            rel    <= 1'b1;
        end else if (rel && !tx_ack) begin
            rel <= 1'b0;
        end
    end

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 prog_we,
    input  core_pkg::imem_addr_t prog_addr,
    input  core_pkg::instr_t     prog_data,
    input  logic                 rx_req,
    input  logic [7:0]           rx_data,
    output logic                 rx_ack,
    output logic                 tx_req,
    output logic [7:0]           tx_data,
    input  logic                 tx_ack,
    output logic                 halted
);
    import core_pkg::*;

    fd_t             fd;
    de_t             de;
    wb_t             wb;
    redirect_t       redirect;
    logic            stall;
    reg_idx_t        ra_a;
    reg_idx_t        ra_b;
    reg_idx_t        ra_j;
    reg_idx_t        set_rd;
    logic            set_en;
    logic [xlen-1:0] rd_a;
    logic [xlen-1:0] rd_b;
    logic [xlen-1:0] rd_j;
    logic            busy_a;
    logic            busy_b;
    logic            busy_j;
    logic            flush_busy;
    logic            ex_branch;
    logic            ex_out;
    logic            tx_load;
    logic [7:0]      tx_byte;
    logic            tx_busy;
    logic            pop;
    logic            word_ok;
    logic [xlen-1:0] rx_word;

    fetch_unit u_fetch (
        .clk, .rstn,
        .prog_we, .prog_addr, .prog_data,
        .stall, .redirect, .halted,
        .jr_src  (rd_j),
        .jr_busy (busy_j),
        .jr_rs   (ra_j),
        .fd
    );

    reg_file u_regs (
        .clk, .rstn,
        .ra_a, .ra_b, .ra_j,
        .set_rd, .set_en, .wb, .flush_busy,
        .rd_a, .rd_b, .rd_j,
        .busy_a, .busy_b, .busy_j
    );

    decode_stage u_decode (
        .clk, .rstn, .fd,
        .rd_a, .rd_b, .busy_a, .busy_b,
        .word_ok, .rx_word, .tx_busy,
        .redirect, .ex_branch, .ex_out,
        .ra_a, .ra_b, .set_rd, .set_en,
        .pop, .stall, .de
    );

    execute_stage u_execute (
        .clk, .rstn, .de,
        .wb, .redirect, .flush_busy,
        .ex_branch, .ex_out,
        .tx_load, .tx_byte, .halted
    );

    rx_buffer u_rx (
        .clk, .rstn,
        .rx_req, .rx_data, .pop,
        .rx_ack, .word_ok, .rx_word
    );

    tx_port u_tx (
        .clk, .rstn,
        .load    (tx_load),
        .byte_in (tx_byte),
        .tx_ack, .tx_req, .tx_data,
        .busy    (tx_busy)
    );

endmodule

// ==== sim/cpu_chk.sv ====
`timescale 1ns/1ps

module cpu_chk (
    input logic       clk,
    input logic       rstn,
    input logic       rx_req,
    input logic       rx_ack,
    input logic       tx_req,
    input logic [7:0] tx_data,
    input logic       tx_ack,
    input logic       halted
);

    // byte held for the whole request
    tx_data_stable: assert property (@(posedge clk) disable iff (!rstn)
        tx_req && $past(tx_req) |-> $stable(tx_data))
        else $error("tx_data changed while tx_req was high");

    tx_req_after_ack: assert property (@(posedge clk) disable iff (!rstn)
        $fell(tx_req) |-> $past(tx_ack))
        else $error("tx_req dropped without tx_ack");

    rx_ack_on_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(rx_ack) |-> $past(rx_req))
        else $error("rx_ack raised without rx_req");

    // halt is sticky until reset
    halted_sticky: assert property (@(posedge clk) disable iff (!rstn)
        !$fell(halted))
        else $error("halted fell while out of reset");

endmodule

bind cpu_top cpu_chk u_chk (
    .clk, .rstn,
    .rx_req, .rx_ack,
    .tx_req, .tx_data, .tx_ack,
    .halted
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
    import core_pkg::*;

    localparam int n_tests      = 5;
    localparam int limit_cycles = n_tests * 400;

    typedef struct packed {
        logic [0:15][31:0] prog;
        logic [3:0]        n_in;
        logic [0:7][7:0]   in_b;
        logic [2:0]        n_out;
        logic [0:3][7:0]   out_b;
        logic [3:0]        ack_slow;
    } row_t;

    logic       clk;
    logic       rstn;
    logic       prog_we;
    imem_addr_t prog_addr;
    instr_t     prog_data;
    logic       rx_req;
    logic [7:0] rx_data;
    logic       rx_ack;
    logic       tx_req;
    logic [7:0] tx_data;
    logic       tx_ack;
    logic       halted;

    row_t       tbl [n_tests];
    string      names [n_tests] = '{"arith_chain", "branches", "call_return",
                                    "input_words", "out_backpressure"};
    logic [7:0] got [$];
    int         cur;
    int         rx_pos;
    logic       running;
    int         errors;
    int         passed;

    cpu_top u_dut (
        .clk, .rstn,
        .prog_we, .prog_addr, .prog_data,
        .rx_req, .rx_data, .rx_ack,
        .tx_req, .tx_data, .tx_ack,
        .halted
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // *************************************************************************
    // instruction encoding
    // *************************************************************************
    function automatic logic [31:0] r_instr(logic [5:0] funct, int rs, int rt, int rd);
        return {op_special, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_instr(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] j_instr(logic [5:0] op, int target);
        return {op, target[25:0]};
    endfunction

    task automatic set_row_io(input int r, input int n_in, input logic [63:0] in_b,
                              input int n_out, input logic [31:0] out_b, input int slow);
        tbl[r].n_in     = n_in[3:0];
        tbl[r].in_b     = in_b;
        tbl[r].n_out    = n_out[2:0];
        tbl[r].out_b    = out_b;
        tbl[r].ack_slow = slow[3:0];
    endtask

    // *************************************************************************
    // test table
    // *************************************************************************
    // unused words stay 0 and decode as ret
    task automatic build_table();
        tbl[0].prog = {
            i_instr(op_addi, 0, 1, 5), i_instr(op_addi, 1, 2, 3),
            r_instr(fn_add, 1, 2, 3), r_instr(fn_out, 3, 0, 0),
            r_instr(fn_sub, 1, 2, 4), r_instr(fn_out, 4, 0, 0),
            r_instr(fn_mov, 4, 5, 0), i_instr(op_slli, 5, 6, 4),
            r_instr(fn_out, 6, 0, 0), i_instr(op_addi, 6, 7, 'h7f),
            r_instr(fn_out, 7, 0, 0), r_instr(fn_ret, 0, 0, 0),
            {4{32'h0}}
        };
        set_row_io(0, 0, 64'h0, 4, 32'h0dfd_d04f, 0);

        // r1 = -2 and r2 = 3
        // words on the wrong path output 0xfe
        tbl[1].prog = {
            i_instr(op_addi, 0, 1, 'hfffe), i_instr(op_addi, 0, 2, 3),
            i_instr(op_bl, 1, 2, 2), r_instr(fn_out, 1, 0, 0),
            i_instr(op_addi, 0, 3, 'h11), r_instr(fn_out, 3, 0, 0),
            i_instr(op_bg, 1, 2, 2), r_instr(fn_out, 2, 0, 0),
            i_instr(op_beq, 2, 2, 2), r_instr(fn_out, 1, 0, 0),
            i_instr(op_bne, 2, 2, 2), i_instr(op_bg, 2, 1, 2),
            r_instr(fn_out, 1, 0, 0), i_instr(op_bl, 2, 1, 2),
            r_instr(fn_out, 1, 0, 0), r_instr(fn_ret, 0, 0, 0)
        };
        set_row_io(1, 0, 64'h0, 3, 32'h1103_fe00, 0);

        // subroutine at 6 and dead code at 5
        tbl[2].prog = {
            i_instr(op_addi, 0, 1, 'h21), j_instr(op_jal, 6),
            i_instr(op_addi, 0, 2, 'h42), r_instr(fn_out, 2, 0, 0),
            j_instr(op_j, 8), r_instr(fn_out, 1, 0, 0),
            r_instr(fn_out, 1, 0, 0), r_instr(fn_jr, 28, 0, 0),
            i_instr(op_addi, 2, 3, 1), r_instr(fn_out, 3, 0, 0),
            r_instr(fn_ret, 0, 0, 0), {5{32'h0}}
        };
        set_row_io(2, 0, 64'h0, 3, 32'h2142_4300, 0);

        // r4 = 0x04030201 so the sub is zero only for little-endian order
        tbl[3].prog = {
            r_instr(fn_in, 1, 0, 0), r_instr(fn_out, 1, 0, 0),
            i_instr(op_addi, 0, 4, 'h0403), i_instr(op_slli, 4, 4, 16),
            i_instr(op_addi, 4, 4, 'h0201), r_instr(fn_sub, 1, 4, 3),
            r_instr(fn_out, 3, 0, 0), r_instr(fn_in, 2, 0, 0),
            r_instr(fn_out, 2, 0, 0), r_instr(fn_ret, 0, 0, 0),
            {6{32'h0}}
        };
        set_row_io(3, 8, 64'h0102_0304_a55a_3cc3, 3, 32'h0100_a500, 0);

        tbl[4].prog = {
            i_instr(op_addi, 0, 1, 'h5a), i_instr(op_addi, 0, 2, 'ha5),
            i_instr(op_addi, 0, 3, 'h3c), i_instr(op_addi, 0, 4, 'hffff),
            r_instr(fn_out, 1, 0, 0), r_instr(fn_out, 2, 0, 0),
            r_instr(fn_out, 3, 0, 0), r_instr(fn_out, 4, 0, 0),
            r_instr(fn_ret, 0, 0, 0), {7{32'h0}}
        };
        set_row_io(4, 0, 64'h0, 4, 32'h5aa5_3cff, 8);
    endtask

    // *************************************************************************
    // byte port agents
    // *************************************************************************
    initial begin : rx_agent
        int gap;
        rx_req  = 1'b0;
        rx_data = 8'h00;
        forever begin
            @(negedge clk);
            if (running && rx_pos < tbl[cur].n_in) begin
                gap = $urandom_range(0, 5);
                repeat (gap) @(negedge clk);
                rx_data = tbl[cur].in_b[rx_pos];
                rx_req  = 1'b1;
                @(negedge clk);
                while (!rx_ack) @(negedge clk);
                rx_req = 1'b0;
                rx_pos++;
                @(negedge clk);
                while (rx_ack) @(negedge clk);
            end
        end
    end

    initial begin : tx_agent
        int dly;
        tx_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_req) begin
                dly = tbl[cur].ack_slow + $urandom_range(0, 5);
                repeat (dly) @(negedge clk);
                got.push_back(tx_data);
                tx_ack = 1'b1;
                while (tx_req) @(negedge clk);
                tx_ack = 1'b0;
            end
        end
    end

    // program is written while reset is held
    task automatic reset_and_load(input int t);
        rstn = 1'b0;
        for (int a = 0; a < 16; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = imem_addr_t'(a);
            prog_data = tbl[t].prog[a];
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic run_row(input int t);
        int sent;
        running = 1'b0;
        cur     = t;
        rx_pos  = 0;
        got.delete();
        reset_and_load(t);
        running = 1'b1;
        while (!halted) @(negedge clk);
        // every out is in tx_port or already sent by the time halted rises
        sent = got.size() + ((tx_req && !tx_ack) ? 1 : 0);
        assert (sent == tbl[t].n_out) else begin
            $display("ERROR %s: bytes out at halt expected %0d, actual %0d",
                     names[t], tbl[t].n_out, sent);
            errors++;
        end
        // last out may still be in its handshake
        while (rx_pos < tbl[t].n_in || rx_req || rx_ack || tx_req || tx_ack) begin
            @(negedge clk);
        end
        running = 1'b0;
    endtask

    task automatic check_row(input int t);
        int n;
        n = tbl[t].n_out;
        assert (got.size() == n) else begin
            $display("ERROR %s: byte count expected %0d, actual %0d",
                     names[t], n, got.size());
            errors++;
        end
        for (int i = 0; i < n && i < got.size(); i++) begin
            assert (got[i] == tbl[t].out_b[i]) else begin
                $display("ERROR %s: byte %0d expected 0x%02h, actual 0x%02h",
                         names[t], i, tbl[t].out_b[i], got[i]);
                errors++;
            end
        end
    endtask

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", limit_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int err_before;
        void'($urandom(33978));
        rstn      = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        running   = 1'b0;
        cur       = 0;
        rx_pos    = 0;
        errors    = 0;
        passed    = 0;
        build_table();

        for (int t = 0; t < n_tests; t++) begin
            err_before = errors;
            run_row(t);
            check_row(t);
            if (errors == err_before) begin
                passed++;
                $display("test %s: ok, %0d bytes", names[t], got.size());
            end else begin
                $display("test %s: FAILED", names[t]);
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, passed, n_tests - passed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/core_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rx_buffer.sv
src/tx_port.sv
src/cpu_top.sv
sim/cpu_chk.sv
sim/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -f verilog.f -o sim_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'No errors'; then
    exit 0
fi
exit 1
